//--- bench/tb_bus_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_controller import bus_types_pkg::*; ();

    localparam int WATCHDOG_CYCLES = 2000;

    logic      clk;
    logic      rst_n_i;
    logic      ic_refill_req_i;
    bus_addr_t ic_refill_addr_i;
    logic      ic_refill_done_o;
    logic      dc_refill_req_i;
    bus_addr_t dc_refill_addr_i;
    logic      dc_refill_done_o;
    logic      dc_wb_req_i;
    bus_addr_t dc_wb_addr_i;
    bus_line_t dc_wb_data_i;
    logic      dc_wb_done_o;
    bus_line_t line_data_o;
    bus_line_t axi_data_i;
    logic      axi_rd_over_i;
    logic      axi_wr_over_i;
    logic      core_wait_i;
    logic      bc_valid_req_o;
    logic      bc_rw_o;
    bus_addr_t bc_addr_o;
    bus_line_t bc_data_o;

    // expected bus order of the running test, done as {ic, dr, wb}
    logic [3:0]       exp_rw;
    bus_addr_t [3:0]  exp_addr;
    bus_line_t [3:0]  exp_data;
    logic [3:0][2:0]  exp_done;
    logic [1:0]       cur_idx;
    logic             cur_rw;
    bus_addr_t        cur_addr;
    bus_line_t        cur_data;
    logic [2:0]       cur_done;
    logic [2:0]       dones;

    integer    seed = 32'h1c04bc6f;
    int        bus_cnt = 0;
    int        base_cnt = 0;
    int        wr_cnt = 0;
    bus_addr_t wr_addr_log [16];
    bus_line_t wr_data_log [16];
    int        ic_done_cnt = 0;
    int        dr_done_cnt = 0;
    int        wb_done_cnt = 0;
    logic      req_seen = 1'b0;
    int        assert_errs = 0;
    int        check_errs = 0;
    int        tests_run = 0;
    int        tests_failed = 0;

    assign cur_idx  = 2'(bus_cnt - base_cnt);
    assign cur_rw   = exp_rw[cur_idx];
    assign cur_addr = exp_addr[cur_idx];
    assign cur_data = exp_data[cur_idx];
    assign cur_done = exp_done[cur_idx];
    assign dones    = {ic_refill_done_o, dc_refill_done_o, dc_wb_done_o};

    bus_controller i_bus_controller (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ic_refill_req_i  (ic_refill_req_i),
        .ic_refill_addr_i (ic_refill_addr_i),
        .ic_refill_done_o (ic_refill_done_o),
        .dc_refill_req_i  (dc_refill_req_i),
        .dc_refill_addr_i (dc_refill_addr_i),
        .dc_refill_done_o (dc_refill_done_o),
        .dc_wb_req_i      (dc_wb_req_i),
        .dc_wb_addr_i     (dc_wb_addr_i),
        .dc_wb_data_i     (dc_wb_data_i),
        .dc_wb_done_o     (dc_wb_done_o),
        .line_data_o      (line_data_o),
        .axi_data_i       (axi_data_i),
        .axi_rd_over_i    (axi_rd_over_i),
        .axi_wr_over_i    (axi_wr_over_i),
        .core_wait_i      (core_wait_i),
        .bc_valid_req_o   (bc_valid_req_o),
        .bc_rw_o          (bc_rw_o),
        .bc_addr_o        (bc_addr_o),
        .bc_data_o        (bc_data_o)
    );

    // word i of a read line is the address xor i
    function automatic bus_line_t model_line(input bus_addr_t addr);
        return {addr ^ 32'd3, addr ^ 32'd2, addr ^ 32'd1, addr ^ 32'd0};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (ic_refill_req_i || dc_refill_req_i || dc_wb_req_i) req_seen <= 1'b1;
        if (ic_refill_done_o) ic_done_cnt <= ic_done_cnt + 1;
        if (dc_refill_done_o) dr_done_cnt <= dr_done_cnt + 1;
        if (dc_wb_done_o) wb_done_cnt <= wb_done_cnt + 1;
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !req_seen |-> !bc_valid_req_o && dones == 3'b000)
    else begin
        assert_errs++;
        $display("mismatch at %0t: bc_valid_req_o/dones expected 0/000 got %b/%b",
                 $time, $sampled(bc_valid_req_o), $sampled(dones));
    end

    a_rw: assert property (@(posedge clk) disable iff (!rst_n_i)
        bc_valid_req_o |-> bc_rw_o == cur_rw)
    else begin
        assert_errs++;
        $display("mismatch at %0t: bc_rw_o expected %b got %b",
                 $time, $sampled(cur_rw), $sampled(bc_rw_o));
    end

    a_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        bc_valid_req_o |-> bc_addr_o == cur_addr)
    else begin
        assert_errs++;
        $display("mismatch at %0t: bc_addr_o expected %h got %h",
                 $time, $sampled(cur_addr), $sampled(bc_addr_o));
    end

    a_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        bc_valid_req_o && bc_rw_o |-> bc_data_o == cur_data)
    else begin
        assert_errs++;
        $display("mismatch at %0t: bc_data_o expected %h got %h",
                 $time, $sampled(cur_data), $sampled(bc_data_o));
    end

    a_done_src: assert property (@(posedge clk) disable iff (!rst_n_i)
        dones != 3'b000 |-> dones == cur_done)
    else begin
        assert_errs++;
        $display("mismatch at %0t: done {ic,dr,wb} expected %b got %b",
                 $time, $sampled(cur_done), $sampled(dones));
    end

    a_line: assert property (@(posedge clk) disable iff (!rst_n_i)
        ic_refill_done_o || dc_refill_done_o |-> line_data_o == model_line(cur_addr))
    else begin
        assert_errs++;
        $display("mismatch at %0t: line_data_o expected %h got %h",
                 $time, model_line($sampled(cur_addr)), $sampled(line_data_o));
    end

    // no new bus request while the core holds the controller
    a_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
        core_wait_i && !bc_valid_req_o |=> !bc_valid_req_o)
    else begin
        assert_errs++;
        $display("mismatch at %0t: bc_valid_req_o expected 0 got 1", $time);
    end

    // bus memory model, answers after 1 to 6 cycles
    initial begin : bus_model
        int unsigned delay;
        axi_data_i    = '0;
        axi_rd_over_i = 1'b0;
        axi_wr_over_i = 1'b0;
        forever begin
            @(negedge clk);
            if (bc_valid_req_o) begin
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(negedge clk);
                if (bc_rw_o) begin
                    wr_addr_log[4'(wr_cnt)] = bc_addr_o;
                    wr_data_log[4'(wr_cnt)] = bc_data_o;
                    wr_cnt = wr_cnt + 1;
                    axi_wr_over_i = 1'b1;
                end else begin
                    axi_data_i    = model_line(bc_addr_o);
                    axi_rd_over_i = 1'b1;
                end
                @(negedge clk);
                axi_rd_over_i = 1'b0;
                axi_wr_over_i = 1'b0;
                // done pulse is sampled before the next entry becomes current
                @(negedge clk);
                bus_cnt = bus_cnt + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic step();
        @(negedge clk);
        // requester lets go once it sees its done
        if (dc_wb_done_o) dc_wb_req_i = 1'b0;
        if (dc_refill_done_o) dc_refill_req_i = 1'b0;
        if (ic_refill_done_o) ic_refill_req_i = 1'b0;
    endtask

    task automatic check_count(input string sig, input int got, input int exp);
        assert (got == exp)
        else begin
            check_errs++;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, sig, exp, got);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (assert_errs + check_errs == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name,
                     assert_errs + check_errs - errs_before);
        end
    endtask

    task automatic run_case(input string name, input logic use_wb, input logic use_dr,
                            input logic use_ic, input logic stall, input bus_addr_t base);
        logic [1:0] k;
        int         n;
        int         errs_before;
        int         wb_before;
        int         dr_before;
        int         ic_before;
        int         wr_before;
        k = 2'd0;
        n = 0;
        errs_before = assert_errs + check_errs;
        @(negedge clk);
        exp_rw   = '0;
        exp_addr = '0;
        exp_data = '0;
        exp_done = '0;
        dc_wb_addr_i     = base + 32'h200;
        dc_wb_data_i     = {~base, base, base ^ 32'hffff_0000, base + 32'h5};
        dc_refill_addr_i = base + 32'h100;
        ic_refill_addr_i = base;
        // bus order follows the fixed priority wb, dr, ic
        if (use_wb) begin
            exp_rw[k]   = 1'b1;
            exp_addr[k] = dc_wb_addr_i;
            exp_data[k] = dc_wb_data_i;
            exp_done[k] = 3'b001;
            k = k + 1'b1;
            n = n + 1;
        end
        if (use_dr) begin
            exp_addr[k] = dc_refill_addr_i;
            exp_done[k] = 3'b010;
            k = k + 1'b1;
            n = n + 1;
        end
        if (use_ic) begin
            exp_addr[k] = ic_refill_addr_i;
            exp_done[k] = 3'b100;
            n = n + 1;
        end
        base_cnt  = bus_cnt;
        wb_before = wb_done_cnt;
        dr_before = dr_done_cnt;
        ic_before = ic_done_cnt;
        wr_before = wr_cnt;
        dc_wb_req_i     = use_wb;
        dc_refill_req_i = use_dr;
        ic_refill_req_i = use_ic;
        if (stall) begin
            while (!bc_valid_req_o) step();
            core_wait_i = 1'b1;
            repeat (20) step();
            core_wait_i = 1'b0;
        end
        while (dc_wb_req_i || dc_refill_req_i || ic_refill_req_i) step();
        repeat (8) step();
        check_count("bus request count", bus_cnt - base_cnt, n);
        check_count("dc_wb_done_o pulses", wb_done_cnt - wb_before, int'(use_wb));
        check_count("dc_refill_done_o pulses", dr_done_cnt - dr_before, int'(use_dr));
        check_count("ic_refill_done_o pulses", ic_done_cnt - ic_before, int'(use_ic));
        check_count("bus write count", wr_cnt - wr_before, int'(use_wb));
        if (use_wb && wr_cnt > wr_before) begin
            assert (wr_addr_log[4'(wr_before)] == base + 32'h200)
            else begin
                check_errs++;
                $display("mismatch at %0t: written bc_addr_o expected %h got %h",
                         $time, base + 32'h200, wr_addr_log[4'(wr_before)]);
            end
            assert (wr_data_log[4'(wr_before)] == dc_wb_data_i)
            else begin
                check_errs++;
                $display("mismatch at %0t: written bc_data_o expected %h got %h",
                         $time, dc_wb_data_i, wr_data_log[4'(wr_before)]);
            end
        end
        report_test(name, errs_before);
    endtask

    initial begin : main
        int errs_before;
        rst_n_i          = 1'b0;
        ic_refill_req_i  = 1'b0;
        ic_refill_addr_i = '0;
        dc_refill_req_i  = 1'b0;
        dc_refill_addr_i = '0;
        dc_wb_req_i      = 1'b0;
        dc_wb_addr_i     = '0;
        dc_wb_data_i     = '0;
        core_wait_i      = 1'b0;
        exp_rw           = '0;
        exp_addr         = '0;
        exp_data         = '0;
        exp_done         = '0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;

        errs_before = assert_errs + check_errs;
        repeat (6) step();
        report_test("reset_idle", errs_before);

        run_case("ic_refill", 1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_1040);
        run_case("writeback", 1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_2080);
        run_case("priority", 1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_30c0);
        run_case("back_pressure", 1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_4100);

        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, assert_errs + check_errs);
        if (assert_errs + check_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/bc_ctrl_pkg.sv
`default_nettype none

`include "bc_defines.svh"

package bc_ctrl_pkg;

    // who asked for the bus transfer
    typedef enum logic [1:0] {
        SRC_DC_WB     = 2'd0,
        SRC_DC_REFILL = 2'd1,
        SRC_IC_REFILL = 2'd2
    } req_src_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_e;

    // free queue slots as seen by the arbiter
    typedef logic [`BC_CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

//--- design/bc_defines.svh
`ifndef BC_DEFINES_SVH
`define BC_DEFINES_SVH

// external line bus
`define BC_ADDR_W       32
`define BC_LINE_W       128

// request queue entries, also the arbiter's starting credit
`define BC_QUEUE_DEPTH  2

// must hold the value BC_QUEUE_DEPTH
`define BC_CREDIT_W     2

`endif

//--- design/bus_controller.sv
`timescale 1ns/1ps
`default_nettype none

module bus_controller import bus_types_pkg::*, bc_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    // instruction cache
    input  logic      ic_refill_req_i,
    input  bus_addr_t ic_refill_addr_i,
    output logic      ic_refill_done_o,

    // data cache
    input  logic      dc_refill_req_i,
    input  bus_addr_t dc_refill_addr_i,
    output logic      dc_refill_done_o,
    input  logic      dc_wb_req_i,
    input  bus_addr_t dc_wb_addr_i,
    input  bus_line_t dc_wb_data_i,
    output logic      dc_wb_done_o,

    output bus_line_t line_data_o,

    // external line bus
    input  bus_line_t axi_data_i,
    input  logic      axi_rd_over_i,
    input  logic      axi_wr_over_i,
    input  logic      core_wait_i,
    output logic      bc_valid_req_o,
    output logic      bc_rw_o,
    output bus_addr_t bc_addr_o,
    output bus_line_t bc_data_o
);

    // arbiter to queue
    logic      q_push;
    req_src_e  q_src;
    logic      q_rw;
    bus_addr_t q_addr;
    bus_line_t q_data;
    logic      q_credit;

    // queue head to sequencer
    logic      q_not_empty;
    logic      q_pop;
    req_src_e  head_src;
    logic      head_rw;
    bus_addr_t head_addr;
    bus_line_t head_data;

    req_arbiter i_req_arbiter (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ic_refill_req_i  (ic_refill_req_i),
        .ic_refill_addr_i (ic_refill_addr_i),
        .dc_refill_req_i  (dc_refill_req_i),
        .dc_refill_addr_i (dc_refill_addr_i),
        .dc_wb_req_i      (dc_wb_req_i),
        .dc_wb_addr_i     (dc_wb_addr_i),
        .dc_wb_data_i     (dc_wb_data_i),
        .q_credit_i       (q_credit),
        .q_push_o         (q_push),
        .q_src_o          (q_src),
        .q_rw_o           (q_rw),
        .q_addr_o         (q_addr),
        .q_data_o         (q_data)
    );

    req_queue i_req_queue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .q_push_i      (q_push),
        .q_src_i       (q_src),
        .q_rw_i        (q_rw),
        .q_addr_i      (q_addr),
        .q_data_i      (q_data),
        .q_pop_i       (q_pop),
        .q_not_empty_o (q_not_empty),
        .q_src_o       (head_src),
        .q_rw_o        (head_rw),
        .q_addr_o      (head_addr),
        .q_data_o      (head_data),
        .q_credit_o    (q_credit)
    );

    bus_sequencer i_bus_sequencer (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .q_not_empty_i    (q_not_empty),
        .q_src_i          (head_src),
        .q_rw_i           (head_rw),
        .q_addr_i         (head_addr),
        .q_data_i         (head_data),
        .q_pop_o          (q_pop),
        .axi_data_i       (axi_data_i),
        .axi_rd_over_i    (axi_rd_over_i),
        .axi_wr_over_i    (axi_wr_over_i),
        .core_wait_i      (core_wait_i),
        .bc_valid_req_o   (bc_valid_req_o),
        .bc_rw_o          (bc_rw_o),
        .bc_addr_o        (bc_addr_o),
        .bc_data_o        (bc_data_o),
        .ic_refill_done_o (ic_refill_done_o),
        .dc_refill_done_o (dc_refill_done_o),
        .dc_wb_done_o     (dc_wb_done_o),
        .line_data_o      (line_data_o)
    );

endmodule

`default_nettype wire

//--- design/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer import bus_types_pkg::*, bc_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      q_not_empty_i,
    input  req_src_e  q_src_i,
    input  logic      q_rw_i,
    input  bus_addr_t q_addr_i,
    input  bus_line_t q_data_i,
    output logic      q_pop_o,

    input  bus_line_t axi_data_i,
    input  logic      axi_rd_over_i,
    input  logic      axi_wr_over_i,
    input  logic      core_wait_i,

    output logic      bc_valid_req_o,
    output logic      bc_rw_o,
    output bus_addr_t bc_addr_o,
    output bus_line_t bc_data_o,

    output logic      ic_refill_done_o,
    output logic      dc_refill_done_o,
    output logic      dc_wb_done_o,
    output bus_line_t line_data_o
);

    seq_state_e state_q;
    req_src_e   src_q;
    logic       bus_over;
    logic       busy;

    assign busy     = (state_q != SEQ_IDLE);
    assign bus_over = busy && (bc_rw_o ? axi_wr_over_i : axi_rd_over_i);

    // take the head only when no transfer is open
    assign q_pop_o = (state_q == SEQ_IDLE) && q_not_empty_i && !core_wait_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q          <= SEQ_IDLE;
            bc_valid_req_o   <= 1'b0;
            ic_refill_done_o <= 1'b0;
            dc_refill_done_o <= 1'b0;
            dc_wb_done_o     <= 1'b0;
        end else begin
            ic_refill_done_o <= 1'b0;
            dc_refill_done_o <= 1'b0;
            dc_wb_done_o     <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (q_pop_o) begin
                        state_q        <= SEQ_ISSUE;
                        bc_valid_req_o <= 1'b1;
                    end
                end
                SEQ_ISSUE, SEQ_WAIT: begin
                    if (bus_over) begin
                        state_q        <= SEQ_IDLE;
                        bc_valid_req_o <= 1'b0;
                        case (src_q)
                            SRC_DC_WB:     dc_wb_done_o     <= 1'b1;
                            SRC_DC_REFILL: dc_refill_done_o <= 1'b1;
                            default:       ic_refill_done_o <= 1'b1;
                        endcase
                    end else begin
                        state_q <= SEQ_WAIT;
                    end
                end
                default: begin
                    state_q        <= SEQ_IDLE;
                    bc_valid_req_o <= 1'b0;
                end
            endcase
        end
    end

    // bus fields held from pop until the over pulse
    always_ff @(posedge clk) begin
        if (q_pop_o) begin
            src_q     <= q_src_i;
            bc_rw_o   <= q_rw_i;
            bc_addr_o <= q_addr_i;
            bc_data_o <= q_data_i;
        end
    end

    // read line lines up with the refill done pulse
    always_ff @(posedge clk) begin
        if (bus_over && !bc_rw_o) begin
            line_data_o <= axi_data_i;
        end
    end

endmodule

`default_nettype wire

//--- design/bus_types_pkg.sv
`default_nettype none

`include "bc_defines.svh"

package bus_types_pkg;

    // line-aligned address on the external bus
    typedef logic [`BC_ADDR_W-1:0] bus_addr_t;

    // one full cache line, four 32-bit words
    typedef logic [`BC_LINE_W-1:0] bus_line_t;

endpackage

`default_nettype wire

//--- design/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bc_defines.svh"

module req_arbiter import bus_types_pkg::*, bc_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      ic_refill_req_i,
    input  bus_addr_t ic_refill_addr_i,
    input  logic      dc_refill_req_i,
    input  bus_addr_t dc_refill_addr_i,
    input  logic      dc_wb_req_i,
    input  bus_addr_t dc_wb_addr_i,
    input  bus_line_t dc_wb_data_i,

    input  logic      q_credit_i,

    output logic      q_push_o,
    output req_src_e  q_src_o,
    output logic      q_rw_o,
    output bus_addr_t q_addr_o,
    output bus_line_t q_data_o
);

    logic      issued_wb_q;
    logic      issued_dr_q;
    logic      issued_ir_q;
    credit_t   credit_q;
    logic      grant;
    req_src_e  sel_src;
    logic      sel_rw;
    bus_addr_t sel_addr;
    bus_line_t sel_data;

    // fixed priority, victim line leaves before its refill
    always_comb begin
        grant   = 1'b0;
        sel_src = SRC_DC_WB;
        if (credit_q != '0) begin
            if (dc_wb_req_i && !issued_wb_q) begin
                grant   = 1'b1;
                sel_src = SRC_DC_WB;
            end else if (dc_refill_req_i && !issued_dr_q) begin
                grant   = 1'b1;
                sel_src = SRC_DC_REFILL;
            end else if (ic_refill_req_i && !issued_ir_q) begin
                grant   = 1'b1;
                sel_src = SRC_IC_REFILL;
            end
        end
    end

    always_comb begin
        sel_rw   = 1'b0;
        sel_addr = ic_refill_addr_i;
        sel_data = '0;
        case (sel_src)
            SRC_DC_WB: begin
                sel_rw   = 1'b1;
                sel_addr = dc_wb_addr_i;
                sel_data = dc_wb_data_i;
            end
            SRC_DC_REFILL: sel_addr = dc_refill_addr_i;
            default:       sel_addr = ic_refill_addr_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            q_push_o    <= 1'b0;
            issued_wb_q <= 1'b0;
            issued_dr_q <= 1'b0;
            issued_ir_q <= 1'b0;
            credit_q    <= credit_t'(`BC_QUEUE_DEPTH);
        end else begin
            q_push_o <= grant;
            // flag stays up until the source drops its request
            issued_wb_q <= dc_wb_req_i && (issued_wb_q || (grant && sel_src == SRC_DC_WB));
            issued_dr_q <= dc_refill_req_i &&
                           (issued_dr_q || (grant && sel_src == SRC_DC_REFILL));
            issued_ir_q <= ic_refill_req_i &&
                           (issued_ir_q || (grant && sel_src == SRC_IC_REFILL));
            case ({grant, q_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (grant) begin
            q_src_o  <= sel_src;
            q_rw_o   <= sel_rw;
            q_addr_o <= sel_addr;
            q_data_o <= sel_data;
        end
    end

endmodule

`default_nettype wire

//--- design/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "bc_defines.svh"

module req_queue import bus_types_pkg::*, bc_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      q_push_i,
    input  req_src_e  q_src_i,
    input  logic      q_rw_i,
    input  bus_addr_t q_addr_i,
    input  bus_line_t q_data_i,

    input  logic      q_pop_i,

    output logic      q_not_empty_o,
    output req_src_e  q_src_o,
    output logic      q_rw_o,
    output bus_addr_t q_addr_o,
    output bus_line_t q_data_o,

    output logic      q_credit_o
);

    localparam int DEPTH = `BC_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    req_src_e   src_mem  [DEPTH];
    logic       rw_mem   [DEPTH];
    bus_addr_t  addr_mem [DEPTH];
    bus_line_t  data_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    assign q_not_empty_o = (count_q != '0);
    assign do_pop        = q_pop_i && q_not_empty_o;

    // head entry, no output register
    assign q_src_o  = src_mem[rd_ptr_q];
    assign q_rw_o   = rw_mem[rd_ptr_q];
    assign q_addr_o = addr_mem[rd_ptr_q];
    assign q_data_o = data_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (q_push_i) begin
            src_mem[wr_ptr_q]  <= q_src_i;
            rw_mem[wr_ptr_q]   <= q_rw_i;
            addr_mem[wr_ptr_q] <= q_addr_i;
            data_mem[wr_ptr_q] <= q_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            q_credit_o <= 1'b0;
        end else begin
            q_credit_o <= do_pop;
            if (q_push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({q_push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_bus_controller \
    -Mdir obj_dir -o sim_bus_controller

./obj_dir/sim_bus_controller > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi

//--- verilog.f
+incdir+design
design/bus_types_pkg.sv
design/bc_ctrl_pkg.sv
design/req_arbiter.sv
design/req_queue.sv
design/bus_sequencer.sv
design/bus_controller.sv
bench/tb_bus_controller.sv
